//--- sources.f
logic/zx_bus_pkg.sv
logic/zx_mem_pkg.sv
logic/bus_capture.sv
logic/port_decoder.sv
logic/paging_regs.sv
logic/ram_mapper.sv
logic/zx_memory_top.sv
bench/zx_memory_props.sv
bench/tb_zx_memory.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the paging core testbench with Verilator.
# The run passes only when the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_zx_memory -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_zx_memory)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- bench/tb_zx_memory.sv
/*
 * Testbench for the paging core. Each table entry resets the DUT with its
 * model, issues up to three I/O writes, then holds one memory access.
 * Expected values come from a behavioural model of the paging rules.
 */
`timescale 1ns/1ps

module tb_zx_memory import zx_bus_pkg::*; import zx_mem_pkg::*; ();

	typedef struct packed {
		mem_model_t       model;
		logic [1:0]       n_io;
		logic [0:2][23:0] ios;           // {port, data} per I/O write
		logic [15:0]      probe_addr;
		logic [7:0]       probe_data;
		logic             probe_wr;      // 0 read, 1 write
	} test_t;

	logic       clk_sys = 1'b0;
	logic       reset;
	mem_model_t model;
	cpu_bus_t   cpu;
	ram_req_t   ram;
	ula_state_t ula;
	logic       page_scr;

	test_t  tbl[$];
	integer seed;
	int     cycles = 0;
	int     limit_cycles = 0;
	int     err_count = 0;
	int     fail_tests = 0;

	zx_memory_top UUT (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model   (model),
		.cpu     (cpu),
		.ram     (ram),
		.ula     (ula),
		.page_scr(page_scr)
	);

	initial begin
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) cycles <= cycles + 1;

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		wait (cycles >= limit_cycles);
		$display("Timeout: tests did not finish within %0d cycles", limit_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [7:0] next_byte();
		return 8'($random(seed));
	endfunction

	task automatic add_test(input mem_model_t m, input logic [15:0] pa, input logic [7:0] pd,
			input logic wr, input int n, input logic [0:2][23:0] ios);
		test_t t;
		t.model      = m;
		t.n_io       = 2'(n);
		t.ios        = ios;
		t.probe_addr = pa;
		t.probe_data = pd;
		t.probe_wr   = wr;
		tbl.push_back(t);
	endtask

	task automatic bus_idle();
		cpu = '{addr: 16'h0000, dout: 8'h00, mreq_n: 1'b1, iorq_n: 1'b1,
			rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};
	endtask

	// ============================================================
	// Reference model of the paging rules
	// ============================================================
	function automatic logic [2:0] special_bank(input logic [1:0] cfg, input logic [1:0] region);
		logic [11:0] layout;    // Region 3 in the top field
		case (cfg)
			2'd0: layout = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1: layout = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2: layout = {3'd3, 3'd6, 3'd5, 3'd4};
			default: layout = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		return layout[region * 3 +: 3];
	endfunction

	task automatic predict(input test_t t, output ram_req_t er, output ula_state_t eu,
			output logic es);
		logic [7:0]  r7;
		logic [7:0]  r1;
		logic [7:0]  re;
		logic [2:0]  ext;
		logic [15:0] a;
		logic [7:0]  d;
		logic        locked;
		logic        take7;
		logic [1:0]  region;
		logic        spec;
		logic [3:0]  rom;
		int          i;
		r7  = '0;
		r1  = '0;
		re  = '0;
		ext = '0;
		eu  = '0;
		for (i = 0; i < int'(t.n_io); i++) begin
			{a, d} = t.ios[i];
			locked = (t.model == MODEL_48) || (t.model != MODEL_P1024 && r7[5])
				|| (t.model == MODEL_P1024 && re[2] && r7[5]);
			// 7FFD, or its A14 low alias everywhere but the +3
			take7 = !locked && !a[15] && !a[1] && (a[14] || t.model != MODEL_PLUS3);
			if (take7 && t.model == MODEL_P1024 && !re[2])
				ext = {d[5], d[7], d[6]};
			if (take7)
				r7 = d;
			else if (a[15:12] == 4'b0001 && !a[1] && t.model == MODEL_PLUS3 && !locked)
				r1 = d;
			if (a == 16'hDFFD && t.model == MODEL_PROFI)
				ext = d[2:0];
			if (a[15:12] == 4'b1110 && !a[3] && t.model == MODEL_P1024)
				re = d;
			if (!a[0])
				eu = '{border: d[2:0], ear: d[4], mic: d[3]};
		end

		region = t.probe_addr[15:14];
		spec   = r1[0];
		if (t.model == MODEL_PLUS3)
			rom = {2'b10, r1[2], r7[4]};
		else
			rom = {3'b011, t.model == MODEL_48 || r7[4]};
		if (spec)
			er.addr = RAM_ADDR_W'({3'b000, special_bank(r1[2:1], region), t.probe_addr[13:0]});
		else if (region == 2'd0)
			er.addr = RAM_ADDR_W'({3'b101, rom, t.probe_addr[13:0]});
		else if (region == 2'd3)
			er.addr = RAM_ADDR_W'({ext, r7[2:0], t.probe_addr[13:0]});
		else
			er.addr = RAM_ADDR_W'({region == 2'd1 ? 6'd5 : 6'd2, t.probe_addr[13:0]});
		er.data = t.probe_data;
		er.rd   = !t.probe_wr;
		er.we   = t.probe_wr && (region != 2'd0 || spec);
		es      = r7[3];    // Shadow screen select
	endtask

	// ============================================================
	// Drivers and checks
	// ============================================================
	task automatic reset_with(input mem_model_t m);
		@(negedge clk_sys);
		reset = 1'b1;
		model = m;
		bus_idle();
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic io_write(input logic [23:0] io);
		@(negedge clk_sys);
		{cpu.addr, cpu.dout} = io;
		cpu.iorq_n = 1'b0;
		cpu.wr_n   = 1'b0;
		repeat (2) @(negedge clk_sys);    // Strobes held two cycles
		bus_idle();
		@(negedge clk_sys);
	endtask

	task automatic check_ram(input ram_req_t got, input ram_req_t exp, input int k);
		if (got !== exp) begin
			$display("ERR %0t: test %0d ram addr %h data %h rd %b we %b, expected %h %h %b %b",
				$time, k, got.addr, got.data, got.rd, got.we,
				exp.addr, exp.data, exp.rd, exp.we);
			err_count++;
		end
	endtask

	task automatic check_ula(input ula_state_t got, input ula_state_t exp, input int k);
		if (got !== exp) begin
			$display("ERR %0t: test %0d ula border %0d ear %b mic %b, expected %0d %b %b",
				$time, k, got.border, got.ear, got.mic, exp.border, exp.ear, exp.mic);
			err_count++;
		end
	endtask

	task automatic check_scr(input logic got, input logic exp, input int k);
		if (got !== exp) begin
			$display("ERR %0t: test %0d page_scr %b, expected %b", $time, k, got, exp);
			err_count++;
		end
	endtask

	task automatic run_test(input int k, input test_t t);
		ram_req_t   er;
		ula_state_t eu;
		logic       es;
		mem_model_t m;
		int         errs_before;
		int         i;
		m = t.model;
		errs_before = err_count;
		reset_with(m);
		for (i = 0; i < int'(t.n_io); i++)
			io_write(t.ios[i]);
		@(negedge clk_sys);
		cpu.addr   = t.probe_addr;
		cpu.dout   = t.probe_data;
		cpu.mreq_n = 1'b0;
		cpu.rd_n   = t.probe_wr;
		cpu.wr_n   = !t.probe_wr;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);    // Sample away from the clock edge
		predict(t, er, eu, es);
		check_ram(ram, er, k);
		check_ula(ula, eu, k);
		check_scr(page_scr, es, k);
		bus_idle();
		if (err_count != errs_before)
			fail_tests++;
		$display("test %0d %s probe %h: %s", k, m.name(), t.probe_addr,
			(err_count == errs_before) ? "ok" : "mismatch");
	endtask

	initial begin
		seed  = 5868;
		reset = 1'b1;
		model = MODEL_128;
		bus_idle();

		add_test(MODEL_128, 16'hC000, 8'h00, 1'b0, 1, {24'h7FFD0B, 48'h0});
		add_test(MODEL_128, 16'h0123, 8'h00, 1'b0, 1, {24'h7FFD10, 48'h0});
		add_test(MODEL_128, 16'h4000, next_byte(), 1'b1, 0, 72'h0);
		add_test(MODEL_128, 16'h8005, next_byte(), 1'b1, 1, {24'h7FFD07, 48'h0});
		add_test(MODEL_128, 16'hC010, 8'h00, 1'b0, 2, {24'h7FFD21, 24'h7FFD04, 24'h0});
		add_test(MODEL_128, 16'h0000, next_byte(), 1'b1, 0, 72'h0);
		add_test(MODEL_P1024, 16'hC000, 8'h00, 1'b0, 2, {24'h7FFD21, 24'h7FFD04, 24'h0});
		add_test(MODEL_P1024, 16'hC000, 8'h00, 1'b0, 3, {24'hEFF704, 24'h7FFD23, 24'h7FFD05});
		add_test(MODEL_P1024, 16'hFFFF, next_byte(), 1'b1, 1, {24'h7FFDE6, 48'h0});
		add_test(MODEL_PROFI, 16'hC123, next_byte(), 1'b1, 2, {24'hDFFD05, 24'h7FFD02, 24'h0});
		add_test(MODEL_48, 16'hC000, 8'h00, 1'b0, 1, {24'h7FFD0B, 48'h0});
		add_test(MODEL_48, 16'h0000, 8'h00, 1'b0, 1, {24'h7FFD17, 48'h0});
		add_test(MODEL_PLUS3, 16'h1000, 8'h00, 1'b0, 2, {24'h1FFD04, 24'h7FFD10, 24'h0});
		add_test(MODEL_PLUS3, 16'h0100, next_byte(), 1'b1, 1, {24'h1FFD07, 48'h0});
		add_test(MODEL_PLUS3, 16'hC000, 8'h00, 1'b0, 1, {24'h1FFD05, 48'h0});
		add_test(MODEL_PLUS3, 16'h4000, next_byte(), 1'b1, 1, {24'h1FFD01, 48'h0});
		add_test(MODEL_PLUS3, 16'h8000, 8'h00, 1'b0, 1, {24'h1FFD03, 48'h0});
		add_test(MODEL_PLUS3, 16'hC000, 8'h00, 1'b0, 1, {24'h3FFD07, 48'h0});
		add_test(MODEL_128, 16'h0000, next_byte(), 1'b1, 1, {24'h00FE1D, 48'h0});
		add_test(MODEL_128, 16'h8000, 8'h00, 1'b0, 0, 72'h0);
		add_test(MODEL_48, 16'h5000, next_byte(), 1'b1, 2,
			{16'h12FE, next_byte(), 24'h7FFD06, 24'h0});

		limit_cycles = tbl.size() * 40 + 100;
		foreach (tbl[k])
			run_test(k, tbl[k]);

		$display("%0d tests run, %0d failed, %0d mismatches", tbl.size(), fail_tests, err_count);
		if (err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- bench/zx_memory_props.sv
/*
 * Concurrent checks on the RAM request and the ULA port.
 * Bound once into ram_mapper and once into paging_regs; each instance
 * ties off the side that its host module does not have.
 */
`timescale 1ns/1ps

module zx_memory_props import zx_mem_pkg::*; (
	input logic       clk_sys,
	input logic       reset,
	input ram_req_t   ram,
	input ula_state_t ula
);

	// ROM images sit above all RAM banks, so no write may land there
	rom_write_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		ram.we |-> (ram.addr[20:18] != ROM_BASE_BITS))
		else $error("RAM write enable raised for a ROM address");

	rd_we_cleared: assert property (@(posedge clk_sys) reset |=> (!ram.rd && !ram.we))
		else $error("RAM strobes still active after reset");

	ear_mic_cleared: assert property (@(posedge clk_sys) reset |=> (!ula.ear && !ula.mic))
		else $error("EAR or MIC still set after reset");

endmodule

bind ram_mapper zx_memory_props u_ram_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ram     (ram),
	.ula     ('0)
);

bind paging_regs zx_memory_props u_ula_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ram     ('0),
	.ula     (ula)
);

//--- logic/zx_memory_top.sv
/*
 * Paging core top. Four stage pipeline from CPU bus to RAM request.
 * An I/O write reaches the RAM mapping three cycles after it is sampled.
 * No back-pressure; every stage takes a new value on every clock.
 */
`timescale 1ns/1ps

module zx_memory_top import zx_bus_pkg::*; import zx_mem_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  mem_model_t model,
	input  cpu_bus_t   cpu,
	output ram_req_t   ram,
	output ula_state_t ula,
	output logic       page_scr
);

	bus_stage_t  stage1;
	io_event_t   ev;
	page_state_t pages;

	bus_capture u_capture (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.stage1  (stage1)
	);

	port_decoder u_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.stage1  (stage1),
		.ev      (ev)
	);

	paging_regs u_paging (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model   (model),
		.ev      (ev),
		.pages   (pages),
		.ula     (ula)
	);

	ram_mapper u_mapper (
		.clk_sys (clk_sys),
		.reset   (reset),
		.stage1  (stage1),
		.pages   (pages),
		.ram     (ram)
	);

	assign page_scr = pages.reg_7ffd[3];    // Shadow screen for video

endmodule

//--- logic/ram_mapper.sv
/*
 * Fourth pipeline stage. Maps the captured CPU address to external RAM.
 * The request is registered once; rd and we follow the bus strobes and
 * are not held. ROM writes are dropped unless +3 all-RAM mode is on.
 */
`timescale 1ns/1ps

module ram_mapper import zx_bus_pkg::*; import zx_mem_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  bus_stage_t  stage1,
	input  page_state_t pages,
	output ram_req_t    ram
);

	logic [1:0]            region;
	logic [13:0]           offset;
	logic                  special;
	logic [3:0]            rom_page;
	logic [5:0]            bank;
	logic [RAM_ADDR_W-1:0] addr_next;
	logic                  rd_next;
	logic                  we_next;

	assign region  = stage1.bus.addr[15:14];
	assign offset  = stage1.bus.addr[13:0];
	assign special = pages.p3ctl.spec.special;

	always_comb begin
		if (pages.is_plus3)
			rom_page = {2'b10, pages.p3ctl.normal.rom_hi, pages.reg_7ffd[4]};
		else
			rom_page = {3'b011, pages.is48 | pages.reg_7ffd[4]};    // 48 ROM forced on 48
	end

	// ============================================================
	// Bank select
	// ============================================================
	always_comb begin
		bank = '0;
		if (special) begin
			case (pages.p3ctl.spec.cfg)
				2'd0: bank = {4'b0000, region};
				2'd1: bank = {4'b0001, region};
				2'd2: bank = (region == 2'd3) ? 6'd3 : {4'b0001, region};
				default: begin
					case (region)
						2'd0: bank = 6'd4;
						2'd1: bank = 6'd7;
						2'd2: bank = 6'd6;
						default: bank = 6'd3;
					endcase
				end
			endcase
		end else begin
			case (region)
				2'd1: bank = BANK_SCREEN;
				2'd2: bank = BANK_MID;
				2'd3: bank = {pages.ext_bank, pages.reg_7ffd[2:0]};
				default: bank = '0;    // ROM, address built below
			endcase
		end
	end

	always_comb begin
		if (!special && region == 2'd0)
			addr_next = RAM_ADDR_W'({ROM_BASE_BITS, rom_page, offset});
		else
			addr_next = RAM_ADDR_W'({bank, offset});

		rd_next = ~stage1.bus.mreq_n & ~stage1.bus.rd_n;
		we_next = ~stage1.bus.mreq_n & ~stage1.bus.wr_n & (region != 2'd0 || special);
	end

	always_ff @(posedge clk_sys) begin
		ram.addr <= addr_next;
		ram.data <= stage1.bus.dout;

		if (reset) begin
			ram.rd <= 1'b0;
			ram.we <= 1'b0;
		end else begin
			ram.rd <= rd_next;
			ram.we <= we_next;
		end
	end

endmodule

//--- logic/paging_regs.sv
/*
 * Third pipeline stage. Holds the paging and ULA port registers.
 * The model input is sampled only while reset is high.
 * Once the lock bit is set, only a reset opens paging again
 * (on Pentagon 1024 the lock also needs EFF7 bit 2).
 */
`timescale 1ns/1ps

module paging_regs import zx_bus_pkg::*; import zx_mem_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  mem_model_t  model,
	input  io_event_t   ev,
	output page_state_t pages,
	output ula_state_t  ula
);

	logic lock;
	logic wr_7ffd;
	logic wr_1ffd;
	logic wr_dffd;
	logic wr_eff7;
	logic wr_ula;

	assign lock = pages.is48
		| (~pages.is_p1024 & pages.reg_7ffd[5])
		| (pages.is_p1024 & pages.reg_eff7[2] & pages.reg_7ffd[5]);

	// +3 decodes A14, so its 7FFD has no low alias
	assign wr_7ffd = ev.valid & ~lock
		& (ev.hit.page_main | (ev.hit.page_low & ~pages.is_plus3));
	assign wr_1ffd = ev.valid & ev.hit.plus3_ctl & pages.is_plus3 & ~lock & ~wr_7ffd;
	assign wr_dffd = ev.valid & ev.hit.profi_ext & pages.is_profi;
	assign wr_eff7 = ev.valid & ev.hit.pent_ext & pages.is_p1024;
	assign wr_ula  = ev.valid & ev.hit.ula;

	// ============================================================
	// Page registers
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pages.model    <= model;
			pages.is48     <= (model == MODEL_48);
			pages.is_p1024 <= (model == MODEL_P1024);
			pages.is_profi <= (model == MODEL_PROFI);
			pages.is_plus3 <= (model == MODEL_PLUS3);
			pages.reg_7ffd <= '0;
			pages.p3ctl    <= '0;
			pages.reg_eff7 <= '0;
			pages.ext_bank <= '0;
		end else begin
			if (wr_7ffd) begin
				pages.reg_7ffd <= ev.data;
				// Pentagon 1024 borrows the top 7FFD bits for bank
				if (pages.is_p1024 && !pages.reg_eff7[2])
					pages.ext_bank <= {ev.data[5], ev.data[7], ev.data[6]};
			end

			if (wr_1ffd)
				pages.p3ctl <= ev.data;

			if (wr_dffd)
				pages.ext_bank <= ev.data[2:0];    // Profi extended bank

			if (wr_eff7)
				pages.reg_eff7 <= ev.data;
		end
	end

	// ============================================================
	// ULA port
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula.border <= '0;
			ula.ear    <= 1'b0;
			ula.mic    <= 1'b0;
		end else if (wr_ula) begin
			ula.border <= ev.data[2:0];
			ula.mic    <= ev.data[3];
			ula.ear    <= ev.data[4];
		end
	end

endmodule

//--- logic/port_decoder.sv
/*
 * Second pipeline stage. Classifies a captured I/O write by address.
 * Knows nothing about the memory model; several hits may be set at once
 * and paging_regs decides which of them count.
 */
`timescale 1ns/1ps

module port_decoder import zx_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  bus_stage_t stage1,
	output io_event_t  ev
);

	port_hit_t hit_now;

	function automatic logic port_match(input logic [15:0] addr, input port_pat_t pat);
		return (addr & pat.mask) == pat.value;
	endfunction

	always_comb begin
		hit_now.ula       = port_match(stage1.bus.addr, PAT_ULA);
		hit_now.page_main = port_match(stage1.bus.addr, PAT_PAGE_MAIN);
		hit_now.page_low  = port_match(stage1.bus.addr, PAT_PAGE_LOW);
		hit_now.plus3_ctl = port_match(stage1.bus.addr, PAT_PLUS3_CTL);
		hit_now.profi_ext = port_match(stage1.bus.addr, PAT_PROFI_EXT);
		hit_now.pent_ext  = port_match(stage1.bus.addr, PAT_PENT_EXT);
	end

	// ============================================================
	// Event register
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (stage1.io_write_edge) begin
			ev.hit  <= hit_now;
			ev.data <= stage1.bus.dout;    // Payload held until next write
		end

		if (reset)
			ev.valid <= 1'b0;
		else
			ev.valid <= stage1.io_write_edge;
	end

endmodule

//--- logic/bus_capture.sv
/*
 * First pipeline stage. Samples the CPU bus on every clock.
 * An I/O write is flagged once on its leading edge, however long the
 * strobes stay low. Strobes are held inactive during reset.
 */
`timescale 1ns/1ps

module bus_capture import zx_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	output bus_stage_t stage1
);

	logic io_wr_now;
	logic io_wr_prev;

	// IORQ with WR outside an M1 cycle, so interrupt acks never count
	assign io_wr_now = ~cpu.iorq_n & ~cpu.wr_n & cpu.m1_n;

	always_ff @(posedge clk_sys) begin
		stage1.bus.addr <= cpu.addr;
		stage1.bus.dout <= cpu.dout;

		if (reset) begin
			stage1.bus.mreq_n    <= 1'b1;
			stage1.bus.iorq_n    <= 1'b1;
			stage1.bus.rd_n      <= 1'b1;
			stage1.bus.wr_n      <= 1'b1;
			stage1.bus.m1_n      <= 1'b1;
			stage1.io_write_edge <= 1'b0;
			io_wr_prev           <= 1'b0;
		end else begin
			stage1.bus.mreq_n    <= cpu.mreq_n;
			stage1.bus.iorq_n    <= cpu.iorq_n;
			stage1.bus.rd_n      <= cpu.rd_n;
			stage1.bus.wr_n      <= cpu.wr_n;
			stage1.bus.m1_n      <= cpu.m1_n;
			stage1.io_write_edge <= io_wr_now & ~io_wr_prev;    // Rising edge only
			io_wr_prev           <= io_wr_now;
		end
	end

endmodule

//--- logic/zx_mem_pkg.sv
/*
 * Memory side types for the paging core.
 * The model is fixed while reset is high and never changes afterwards.
 * Page registers keep the full written byte, even bits that nothing reads.
 * RAM addresses are 25 bits; ROM images live above 0x140000.
 */
package zx_mem_pkg;

	localparam int RAM_ADDR_W = 25;

	typedef enum logic [2:0] {
		MODEL_128   = 3'd0,
		MODEL_P1024 = 3'd1,
		MODEL_PROFI = 3'd2,
		MODEL_48    = 3'd3,
		MODEL_PLUS3 = 3'd4
	} mem_model_t;

	// ============================================================
	// 1FFD, one byte read two ways depending on bit 0
	// ============================================================
	typedef struct packed {
		logic [3:0] spare;
		logic       motor;      // Disk motor
		logic       rom_hi;     // High ROM select bit
		logic       rsvd;
		logic       special;
	} plus3_normal_t;

	typedef struct packed {
		logic [4:0] spare;
		logic [1:0] cfg;        // All-RAM layout
		logic       special;
	} plus3_special_t;

	typedef union packed {
		plus3_normal_t  normal;
		plus3_special_t spec;
	} plus3_ctl_u;

	typedef struct packed {
		logic [7:0] reg_7ffd;
		plus3_ctl_u p3ctl;
		logic [7:0] reg_eff7;
		logic [2:0] ext_bank;   // Upper bank bits for 1024K models
		mem_model_t model;
		logic       is48;
		logic       is_p1024;
		logic       is_profi;
		logic       is_plus3;
	} page_state_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_state_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  rd;
		logic                  we;
	} ram_req_t;

	localparam logic [5:0] BANK_SCREEN   = 6'd5;
	localparam logic [5:0] BANK_MID      = 6'd2;
	localparam logic [2:0] ROM_BASE_BITS = 3'b101;

endpackage

//--- logic/zx_bus_pkg.sv
/*
 * Z80 bus side types for the paging core.
 * All CPU strobes are active low and are sampled as plain levels.
 * Port patterns are mask/value pairs over the full 16-bit I/O address,
 * as the partial decoding of the original machines requires.
 */
package zx_bus_pkg;

	// Raw CPU bus as seen on the pins
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;    // CPU data out
		logic        mreq_n;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
		logic        m1_n;
	} cpu_bus_t;

	typedef struct packed {
		cpu_bus_t bus;
		logic     io_write_edge;    // One cycle per I/O write
	} bus_stage_t;

	typedef struct packed {
		logic ula;
		logic page_main;    // 7FFD
		logic page_low;     // 7FFD alias with A14 low
		logic plus3_ctl;    // 1FFD
		logic profi_ext;    // DFFD
		logic pent_ext;     // EFF7
	} port_hit_t;

	typedef struct packed {
		port_hit_t   hit;
		logic [7:0]  data;
		logic        valid;
	} io_event_t;

	typedef struct packed {
		logic [15:0] mask;
		logic [15:0] value;
	} port_pat_t;

	localparam logic [15:0] PORT_PROFI_EXT = 16'hDFFD;

	// Address bits that matter per port
	localparam port_pat_t PAT_ULA       = '{mask: 16'h0001, value: 16'h0000};
	localparam port_pat_t PAT_PAGE_MAIN = '{mask: 16'hC002, value: 16'h4000};
	localparam port_pat_t PAT_PAGE_LOW  = '{mask: 16'hC002, value: 16'h0000};
	localparam port_pat_t PAT_PLUS3_CTL = '{mask: 16'hF002, value: 16'h1000};
	localparam port_pat_t PAT_PROFI_EXT = '{mask: 16'hFFFF, value: PORT_PROFI_EXT};
	localparam port_pat_t PAT_PENT_EXT  = '{mask: 16'hF008, value: 16'hE000};

endpackage
